/* rtl/cpuPkg.sv */
package cpuPkg;

    // ################################################
    // Data widths.
    // ################################################

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  psr_t;

    // Status bit positions.
    localparam int PSR_N = 7;
    localparam int PSR_V = 6;
    localparam int PSR_Z = 1;
    localparam int PSR_C = 0;

    // ################################################
    // Control encodings.
    // ################################################

    typedef enum logic [3:0] {
        Reset0, Reset1, Fetch, Decode, Operand1,
        Operand2, Execute, BranchTake, BranchFix, Write
    } cycle_t;

    typedef enum logic [2:0] {
        Pass, Adc, And, Eor, SetCarry, ClearCarry
    } aluOp_t;

    typedef enum logic [1:0] {
        Pc, Operand, Vector
    } addrSel_t;

    // Clocks per bus cycle.
    localparam int STEP_DIV = 4;
    typedef logic [$clog2(STEP_DIV)-1:0] stepCount_t;

    localparam addr_t RESET_VECTOR = 16'hFFFC;

    // Supported opcodes.
    localparam byte_t OP_LDA_IMM = 8'hA9;
    localparam byte_t OP_LDA_ABS = 8'hAD;
    localparam byte_t OP_STA_ABS = 8'h8D;
    localparam byte_t OP_ADC_IMM = 8'h69;
    localparam byte_t OP_AND_IMM = 8'h29;
    localparam byte_t OP_EOR_IMM = 8'h49;
    localparam byte_t OP_CLC     = 8'h18;
    localparam byte_t OP_SEC     = 8'h38;
    localparam byte_t OP_JMP_ABS = 8'h4C;
    localparam byte_t OP_BEQ     = 8'hF0;
    localparam byte_t OP_BNE     = 8'hD0;
    localparam byte_t OP_BCS     = 8'hB0;
    localparam byte_t OP_BCC     = 8'h90;

endpackage

/* rtl/sequencer.sv */
module sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             ready,
    input  cpuPkg::byte_t    dataBusInput,
    input  cpuPkg::psr_t     psr,
    input  logic             pageCross,
    output logic             advance,
    output logic             sync,
    output logic             readNotWrite,
    output logic             pcInc,
    output logic             pcLoad,
    output logic             pcBranch,
    output logic             opLowLoad,
    output logic             opHighLoad,
    output logic             vectorLoad,
    output cpuPkg::addrSel_t addrSel,
    output cpuPkg::aluOp_t   aluOp,
    output logic             accLoad,
    output logic             psrLoad,
    output logic             dataOutLoad
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        ClsImplied, ClsFlag, ClsImmediate, ClsAbsRead, ClsAbsWrite, ClsJump, ClsBranch
    } opClass_t;

    stepCount_t stepCount;
    logic       step;
    byte_t      opcode;
    byte_t      decodeByte;
    opClass_t   opClass;
    aluOp_t     decodedOp;
    logic       branchTaken;
    cycle_t     state, nextState;

    // ################################################
    // Bus cycle step.
    // ################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            stepCount <= '0;
        end else if (stepCount == stepCount_t'(STEP_DIV - 1)) begin
            stepCount <= '0;
        end else begin
            stepCount <= stepCount + 1'b1;
        end
    end

    assign step         = (stepCount == stepCount_t'(STEP_DIV - 1));
    // Bus is idle and strobes are quiet during reset.
    assign readNotWrite = rst | (state != Write);
    assign sync         = ~rst & (state == Fetch);
    // Ready only holds off reads.
    assign advance      = step & ~rst & (ready | ~readNotWrite);

    // ################################################
    // Opcode register and decode.
    // ################################################

    always_ff @(posedge clk) begin
        if (advance && state == Fetch) begin
            opcode <= dataBusInput;
        end
    end

    // The fetch cycle looks ahead at the bus to pick its successor.
    assign decodeByte = (state == Fetch) ? dataBusInput : opcode;

    always_comb begin
        opClass   = ClsImplied;
        decodedOp = Pass;
        case (decodeByte)
            OP_LDA_IMM: opClass = ClsImmediate;
            OP_LDA_ABS: opClass = ClsAbsRead;
            OP_STA_ABS: opClass = ClsAbsWrite;
            OP_ADC_IMM: begin
                opClass   = ClsImmediate;
                decodedOp = Adc;
            end
            OP_AND_IMM: begin
                opClass   = ClsImmediate;
                decodedOp = And;
            end
            OP_EOR_IMM: begin
                opClass   = ClsImmediate;
                decodedOp = Eor;
            end
            OP_CLC: begin
                opClass   = ClsFlag;
                decodedOp = ClearCarry;
            end
            OP_SEC: begin
                opClass   = ClsFlag;
                decodedOp = SetCarry;
            end
            OP_JMP_ABS: opClass = ClsJump;
            OP_BEQ, OP_BNE, OP_BCS, OP_BCC: opClass = ClsBranch;
            default: opClass = ClsImplied;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_BEQ:  branchTaken = psr[PSR_Z];
            OP_BNE:  branchTaken = ~psr[PSR_Z];
            OP_BCS:  branchTaken = psr[PSR_C];
            OP_BCC:  branchTaken = ~psr[PSR_C];
            default: branchTaken = 1'b0;
        endcase
    end

    assign aluOp = decodedOp;

    // ################################################
    // Cycle state machine.
    // ################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Reset0;
        end else if (advance) begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = Fetch;
        case (state)
            Reset0: nextState = Reset1;
            Reset1: nextState = Fetch;
            Fetch: begin
                if (opClass inside {ClsAbsRead, ClsAbsWrite, ClsJump}) begin
                    nextState = Operand1;
                end else begin
                    nextState = Decode;
                end
            end
            Decode: begin
                if (opClass == ClsBranch && branchTaken) begin
                    nextState = BranchTake;
                end
            end
            Operand1: nextState = Operand2;
            Operand2: begin
                if (opClass == ClsAbsRead) begin
                    nextState = Execute;
                end else if (opClass == ClsAbsWrite) begin
                    nextState = Write;
                end
            end
            BranchTake: nextState = pageCross ? BranchFix : Fetch;
            default: nextState = Fetch;
        endcase
    end

    always_comb begin
        case (state)
            Reset0, Reset1:  addrSel = Vector;
            Execute, Write:  addrSel = Operand;
            default:         addrSel = Pc;
        endcase
    end

    // Strobes fire only on the advancing clock.
    always_comb begin
        pcInc       = 1'b0;
        pcLoad      = 1'b0;
        pcBranch    = 1'b0;
        opLowLoad   = 1'b0;
        opHighLoad  = 1'b0;
        vectorLoad  = 1'b0;
        accLoad     = 1'b0;
        psrLoad     = 1'b0;
        dataOutLoad = 1'b0;
        if (advance) begin
            case (state)
                Reset0, Reset1: vectorLoad = 1'b1;
                Fetch:          pcInc = 1'b1;
                Decode: begin
                    case (opClass)
                        ClsImmediate: begin
                            pcInc   = 1'b1;
                            accLoad = 1'b1;
                            psrLoad = 1'b1;
                        end
                        ClsFlag: psrLoad = 1'b1;
                        ClsBranch: begin
                            opLowLoad = 1'b1;
                            pcBranch  = branchTaken;
                            pcInc     = ~branchTaken;
                        end
                        default: pcInc = 1'b0;
                    endcase
                end
                Operand1: begin
                    pcInc     = 1'b1;
                    opLowLoad = 1'b1;
                end
                Operand2: begin
                    pcLoad      = (opClass == ClsJump);
                    pcInc       = (opClass != ClsJump);
                    opHighLoad  = (opClass != ClsJump);
                    dataOutLoad = (opClass == ClsAbsWrite);
                end
                Execute: begin
                    accLoad = 1'b1;
                    psrLoad = 1'b1;
                end
                BranchFix: pcBranch = 1'b1;
                default: pcInc = 1'b0;
            endcase
        end
    end

    // ################################################
    // Checks.
    // ################################################

    syncIsRead: assert property (@(posedge clk) disable iff (rst)
        !(sync && !readNotWrite));

    legalState: assert property (@(posedge clk) disable iff (rst)
        state inside {Reset0, Reset1, Fetch, Decode, Operand1, Operand2,
                      Execute, BranchTake, BranchFix, Write});

endmodule

/* rtl/addressUnit.sv */
module addressUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             advance,
    input  logic             pcInc,
    input  logic             pcLoad,
    input  logic             pcBranch,
    input  logic             opLowLoad,
    input  logic             opHighLoad,
    input  logic             vectorLoad,
    input  cpuPkg::addrSel_t addrSel,
    input  cpuPkg::byte_t    dataBusInput,
    output cpuPkg::addr_t    address,
    output logic             pageCross
);
    import cpuPkg::*;

    byte_t      pcLow, pcHigh;
    byte_t      opLow, opHigh;
    logic       vectorHigh;
    addr_t      pcPlusOne;
    logic [8:0] branchSum;
    byte_t      fixedHigh;

    assign pcPlusOne = {pcHigh, pcLow} + 16'd1;

    // Offset is added to the low byte of the address after the offset byte.
    assign branchSum = {1'b0, pcPlusOne[7:0]} + {1'b0, dataBusInput};
    // Backward branches borrow, forward branches carry.
    assign fixedHigh = opLow[7] ? pcHigh - 8'd1 : pcHigh + 8'd1;

    // ################################################
    // Program counter.
    // ################################################

    always_ff @(posedge clk) begin
        if (advance) begin
            if (vectorLoad) begin
                if (vectorHigh) begin
                    pcHigh <= dataBusInput;
                end else begin
                    pcLow <= dataBusInput;
                end
            end else if (pcLoad) begin
                pcLow  <= opLow;
                pcHigh <= dataBusInput;
            end else if (pcBranch) begin
                if (pageCross) begin
                    pcHigh <= fixedHigh;
                end else begin
                    pcLow  <= branchSum[7:0];
                    pcHigh <= pcPlusOne[15:8];
                end
            end else if (pcInc) begin
                {pcHigh, pcLow} <= pcPlusOne;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vectorHigh <= 1'b0;
            pageCross  <= 1'b0;
        end else if (advance) begin
            if (vectorLoad) begin
                vectorHigh <= ~vectorHigh;
            end
            if (pcBranch) begin
                pageCross <= pageCross ? 1'b0 : (branchSum[8] ^ dataBusInput[7]);
            end
        end
    end

    // Operand latches.
    always_ff @(posedge clk) begin
        if (advance && opLowLoad) begin
            opLow <= dataBusInput;
        end
        if (advance && opHighLoad) begin
            opHigh <= dataBusInput;
        end
    end

    always_comb begin
        case (addrSel)
            Operand: address = {opHigh, opLow};
            Vector:  address = {RESET_VECTOR[15:1], vectorHigh};
            default: address = {pcHigh, pcLow};
        endcase
    end

    oneSource: assert property (@(posedge clk) disable iff (rst)
        !(pcLoad && pcBranch));

endmodule

/* rtl/aluUnit.sv */
module aluUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           advance,
    input  cpuPkg::aluOp_t aluOp,
    input  logic           accLoad,
    input  logic           psrLoad,
    input  logic           dataOutLoad,
    input  cpuPkg::byte_t  dataBusInput,
    output cpuPkg::psr_t   psr,
    output cpuPkg::byte_t  dataBusOutput
);
    import cpuPkg::*;

    byte_t      acc;
    byte_t      result;
    psr_t       nextPsr;
    logic [8:0] sum;

    // Binary add with carry in.
    assign sum = {1'b0, acc} + {1'b0, dataBusInput} + {8'd0, psr[PSR_C]};

    // ################################################
    // ALU and flags.
    // ################################################

    always_comb begin
        result  = acc;
        nextPsr = psr;
        case (aluOp)
            Pass: result = dataBusInput;
            Adc: begin
                result         = sum[7:0];
                nextPsr[PSR_C] = sum[8];
                nextPsr[PSR_V] = (acc[7] == dataBusInput[7]) && (sum[7] != acc[7]);
            end
            And:        result = acc & dataBusInput;
            Eor:        result = acc ^ dataBusInput;
            SetCarry:   nextPsr[PSR_C] = 1'b1;
            ClearCarry: nextPsr[PSR_C] = 1'b0;
            default:    result = acc;
        endcase
        if (aluOp inside {Pass, Adc, And, Eor}) begin
            nextPsr[PSR_N] = result[7];
            nextPsr[PSR_Z] = (result == 8'd0);
        end
    end

    // ################################################
    // Registers.
    // ################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= 8'd0;
            psr <= 8'd0;
        end else if (advance) begin
            if (accLoad) begin
                acc <= result;
            end
            if (psrLoad) begin
                psr <= nextPsr;
            end
        end
    end

    // Held for the whole write cycle.
    always_ff @(posedge clk) begin
        if (advance && dataOutLoad) begin
            dataBusOutput <= acc;
        end
    end

endmodule

/* rtl/cpuTop.sv */
module cpuTop (
    input  logic          clk,
    input  logic          rst,
    input  logic          ready,
    input  cpuPkg::byte_t dataBusInput,
    output cpuPkg::byte_t dataBusOutput,
    output cpuPkg::byte_t addressBusHigh,
    output cpuPkg::byte_t addressBusLow,
    output logic          sync,
    output logic          readNotWrite
);
    import cpuPkg::*;

    addr_t    address;
    psr_t     psr;
    logic     pageCross;
    logic     advance;
    logic     pcInc, pcLoad, pcBranch;
    logic     opLowLoad, opHighLoad, vectorLoad;
    addrSel_t addrSel;
    aluOp_t   aluOp;
    logic     accLoad, psrLoad, dataOutLoad;

    assign addressBusHigh = address[15:8];
    assign addressBusLow  = address[7:0];

    sequencer sequencer (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .dataBusInput (dataBusInput),
        .psr          (psr),
        .pageCross    (pageCross),
        .advance      (advance),
        .sync         (sync),
        .readNotWrite (readNotWrite),
        .pcInc        (pcInc),
        .pcLoad       (pcLoad),
        .pcBranch     (pcBranch),
        .opLowLoad    (opLowLoad),
        .opHighLoad   (opHighLoad),
        .vectorLoad   (vectorLoad),
        .addrSel      (addrSel),
        .aluOp        (aluOp),
        .accLoad      (accLoad),
        .psrLoad      (psrLoad),
        .dataOutLoad  (dataOutLoad)
    );

    addressUnit addressUnit (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .pcInc        (pcInc),
        .pcLoad       (pcLoad),
        .pcBranch     (pcBranch),
        .opLowLoad    (opLowLoad),
        .opHighLoad   (opHighLoad),
        .vectorLoad   (vectorLoad),
        .addrSel      (addrSel),
        .dataBusInput (dataBusInput),
        .address      (address),
        .pageCross    (pageCross)
    );

    aluUnit aluUnit (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .aluOp         (aluOp),
        .accLoad       (accLoad),
        .psrLoad       (psrLoad),
        .dataOutLoad   (dataOutLoad),
        .dataBusInput  (dataBusInput),
        .psr           (psr),
        .dataBusOutput (dataBusOutput)
    );

endmodule

/* bench/tbMemory.sv */
module tbMemory (
    input  logic          clk,
    input  logic          clear,
    input  cpuPkg::addr_t address,
    input  logic          readNotWrite,
    input  cpuPkg::byte_t writeData,
    output cpuPkg::byte_t readData
);
    import cpuPkg::*;

    localparam int LOG_DEPTH = 256;

    byte_t mem [0:65535];
    addr_t logAddr [0:LOG_DEPTH-1];
    byte_t logData [0:LOG_DEPTH-1];
    int    writeCount;
    logic  wasWrite;

    assign readData = mem[address];

    // One record per write bus cycle.
    always_ff @(posedge clk) begin
        if (clear) begin
            writeCount <= 0;
            wasWrite   <= 1'b0;
        end else begin
            wasWrite <= !readNotWrite;
            if (!readNotWrite && !wasWrite && writeCount < LOG_DEPTH) begin
                logAddr[writeCount[7:0]] <= address;
                logData[writeCount[7:0]] <= writeData;
                writeCount               <= writeCount + 1;
            end
        end
    end

endmodule

/* bench/tbCpu.sv */
module tbCpu;
    import cpuPkg::*;

    localparam int BUDGET_RESET     = 10;
    localparam int BUDGET_LOADSTORE = 40;
    localparam int BUDGET_ARITH     = 250;
    localparam int BUDGET_BRANCH    = 30;
    localparam int BUDGET_SYNC      = 20;
    localparam int BUDGET_STALL     = 150;
    localparam int TOTAL_BUDGET = BUDGET_RESET + BUDGET_LOADSTORE + 3 * BUDGET_ARITH
                                + 16 * BUDGET_BRANCH + 5 * BUDGET_SYNC + 2 * BUDGET_STALL;
    localparam longint WATCHDOG_TIME = longint'(TOTAL_BUDGET + 100) * STEP_DIV * 40;

    logic  clk;
    logic  rst;
    logic  ready;
    byte_t dataIn;
    byte_t dataOut;
    byte_t addrHigh;
    byte_t addrLow;
    logic  sync;
    logic  readNotWrite;
    addr_t busAddr;

    int    seed;
    int    clockCount;
    logic  stallMode;
    logic  stallBits [0:1023];
    addr_t progPtr;

    // Sync monitor state.
    int    syncCount;
    addr_t syncAddr [0:63];
    int    syncClock [0:63];
    logic  prevSync;
    logic  stallPending;
    addr_t stallAddr;

    assign busAddr = {addrHigh, addrLow};

    cpuTop u_dut (
        .clk            (clk),
        .rst            (rst),
        .ready          (ready),
        .dataBusInput   (dataIn),
        .dataBusOutput  (dataOut),
        .addressBusHigh (addrHigh),
        .addressBusLow  (addrLow),
        .sync           (sync),
        .readNotWrite   (readNotWrite)
    );

    tbMemory u_mem (
        .clk          (clk),
        .clear        (rst),
        .address      (busAddr),
        .readNotWrite (readNotWrite),
        .writeData    (dataOut),
        .readData     (dataIn)
    );

    // ################################################
    // Clock, ready and monitors.
    // ################################################

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        clockCount <= clockCount + 1;
    end

    initial begin
        ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            ready = stallMode ? stallBits[clockCount[9:0]] : 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            syncCount    = 0;
            prevSync     = 1'b0;
            stallPending = 1'b0;
        end else begin
            // A stalled read keeps its address.
            if (stallPending) begin
                checkValue("address during stall", 32'(busAddr), 32'(stallAddr));
            end
            stallPending = !ready && readNotWrite;
            stallAddr    = busAddr;
            if (sync && !prevSync && syncCount < 64) begin
                syncAddr[syncCount[5:0]]  = busAddr;
                syncClock[syncCount[5:0]] = clockCount;
                syncCount                 = syncCount + 1;
            end
            prevSync = sync;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        stopWithError("Watchdog expired before the tests finished");
    end

    // ################################################
    // Helpers.
    // ################################################

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            stopWithError($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    task automatic fillMemory();
        int a;
        for (a = 0; a < 65536; a++) begin
            u_mem.mem[addr_t'(a)] = byte_t'(a[7:0] ^ a[15:8] ^ 8'hA5);
        end
    endtask

    task automatic emitByte(input byte_t b);
        u_mem.mem[progPtr] = b;
        progPtr = progPtr + 16'd1;
    endtask

    task automatic emitAbs(input byte_t op, input addr_t a);
        emitByte(op);
        emitByte(a[7:0]);
        emitByte(a[15:8]);
    endtask

    task automatic startProgram(input addr_t a);
        progPtr = a;
        u_mem.mem[RESET_VECTOR] = a[7:0];
        u_mem.mem[RESET_VECTOR + 16'd1] = a[15:8];
    endtask

    task automatic jumpSelf();
        emitAbs(OP_JMP_ABS, progPtr);
    endtask

    task automatic pulseReset();
        @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic waitForWrites(input int count, input int budget);
        int limit;
        limit = clockCount + budget * STEP_DIV;
        while (u_mem.writeCount < count) begin
            if (clockCount > limit) begin
                stopWithError("Timed out waiting for bus writes from the DUT");
            end
            @(negedge clk);
        end
    endtask

    task automatic waitForSyncs(input int count, input int budget);
        int limit;
        limit = clockCount + budget * STEP_DIV;
        while (syncCount < count) begin
            if (clockCount > limit) begin
                stopWithError("Timed out waiting for opcode fetches from the DUT");
            end
            @(negedge clk);
        end
    endtask

    // Relative target from the address after the offset byte.
    function automatic addr_t branchTarget(input addr_t next, input byte_t offset);
        return next + {{8{offset[7]}}, offset};
    endfunction

    task automatic checkSyncStep(input int idx, input addr_t expAddr, input int expCycles);
        checkValue("sync address", 32'(syncAddr[idx]), 32'(expAddr));
        checkValue("bus cycles between syncs",
                   32'((syncClock[idx] - syncClock[idx - 1]) / STEP_DIV), 32'(expCycles));
    endtask

    // ################################################
    // Directed tests.
    // ################################################

    task automatic resetVectorTest();
        startProgram(16'h3A7C);
        emitByte(8'hEA);
        jumpSelf();
        pulseReset();
        waitForSyncs(1, BUDGET_RESET);
        checkValue("first sync address", 32'(syncAddr[0]), 32'h3A7C);
        checkValue("writes before first sync", 32'(u_mem.writeCount), 32'd0);
    endtask

    task automatic loadStoreTest();
        startProgram(16'h0200);
        u_mem.mem[16'h1234] = 8'hC3;
        emitByte(OP_LDA_IMM);
        emitByte(8'h5E);
        emitAbs(OP_STA_ABS, 16'h3000);
        emitAbs(OP_LDA_ABS, 16'h1234);
        emitAbs(OP_STA_ABS, 16'h3001);
        jumpSelf();
        pulseReset();
        waitForWrites(2, BUDGET_LOADSTORE);
        checkValue("write address 0", 32'(u_mem.logAddr[0]), 32'h3000);
        checkValue("write data 0", 32'(u_mem.logData[0]), 32'h5E);
        checkValue("write address 1", 32'(u_mem.logAddr[1]), 32'h3001);
        checkValue("write data 1", 32'(u_mem.logData[1]), 32'hC3);
    endtask

    task automatic arithTest(input byte_t op);
        byte_t aVals [0:19];
        byte_t bVals [0:19];
        logic  carry [0:19];
        int    i;
        int    r;
        int    sum;
        byte_t expected;
        startProgram(16'h0200);
        for (i = 0; i < 20; i++) begin
            r        = $random(seed);
            aVals[i] = r[7:0];
            bVals[i] = r[15:8];
            carry[i] = r[16];
            emitByte(carry[i] ? OP_SEC : OP_CLC);
            emitByte(OP_LDA_IMM);
            emitByte(aVals[i]);
            emitByte(op);
            emitByte(bVals[i]);
            emitAbs(OP_STA_ABS, addr_t'(16'h3000 + i));
        end
        jumpSelf();
        pulseReset();
        waitForWrites(20, BUDGET_ARITH);
        for (i = 0; i < 20; i++) begin
            sum = int'(aVals[i]) + int'(bVals[i]) + (carry[i] ? 1 : 0);
            case (op)
                OP_ADC_IMM: expected = sum[7:0];
                OP_AND_IMM: expected = aVals[i] & bVals[i];
                default:    expected = aVals[i] ^ bVals[i];
            endcase
            checkValue("arith write address", 32'(u_mem.logAddr[i]), 32'(16'h3000 + i));
            checkValue("arith write data", 32'(u_mem.logData[i]), 32'(expected));
        end
    endtask

    task automatic branchConditionTest();
        byte_t ops [0:3];
        int    br;
        int    zeroCase;
        int    c;
        byte_t v;
        logic  taken;
        ops[0] = OP_BEQ;
        ops[1] = OP_BNE;
        ops[2] = OP_BCS;
        ops[3] = OP_BCC;
        for (br = 0; br < 4; br++) begin
            for (zeroCase = 0; zeroCase < 2; zeroCase++) begin
                for (c = 0; c < 2; c++) begin
                    v = (zeroCase == 1) ? 8'h00 : 8'h5C;
                    case (br)
                        0:       taken = (v == 8'h00);
                        1:       taken = (v != 8'h00);
                        2:       taken = (c == 1);
                        default: taken = (c == 0);
                    endcase
                    // Taken path skips the marker store of 11.
                    startProgram(16'h0400);
                    emitByte(OP_LDA_IMM);
                    emitByte(v);
                    emitByte((c == 1) ? OP_SEC : OP_CLC);
                    emitByte(ops[br]);
                    emitByte(8'h05);
                    emitByte(OP_LDA_IMM);
                    emitByte(8'h11);
                    emitAbs(OP_STA_ABS, 16'h3100);
                    emitByte(OP_LDA_IMM);
                    emitByte(8'h22);
                    emitAbs(OP_STA_ABS, 16'h3100);
                    jumpSelf();
                    pulseReset();
                    waitForWrites(1, BUDGET_BRANCH);
                    checkValue("branch marker address", 32'(u_mem.logAddr[0]), 32'h3100);
                    checkValue("branch marker data", 32'(u_mem.logData[0]),
                               taken ? 32'h22 : 32'h11);
                end
            end
        end
    endtask

    task automatic branchNearTest();
        addr_t target;
        target = branchTarget(16'h0604, 8'h10);
        startProgram(16'h0600);
        emitByte(OP_LDA_IMM);
        emitByte(8'h00);
        emitByte(OP_BEQ);
        emitByte(8'h10);
        progPtr = target;
        jumpSelf();
        pulseReset();
        waitForSyncs(3, BUDGET_SYNC);
        checkSyncStep(1, 16'h0602, 2);
        checkSyncStep(2, target, 3);
    endtask

    task automatic branchCrossTest();
        addr_t target;
        target = branchTarget(16'h0504, 8'hF0);
        startProgram(16'h0500);
        emitByte(OP_LDA_IMM);
        emitByte(8'h00);
        emitByte(OP_BEQ);
        emitByte(8'hF0);
        progPtr = target;
        jumpSelf();
        pulseReset();
        waitForSyncs(3, BUDGET_SYNC);
        checkSyncStep(1, 16'h0502, 2);
        checkSyncStep(2, target, 4);
    endtask

    task automatic jumpTest();
        startProgram(16'h0700);
        emitAbs(OP_JMP_ABS, 16'h2345);
        progPtr = 16'h2345;
        jumpSelf();
        pulseReset();
        waitForSyncs(2, BUDGET_SYNC);
        checkSyncStep(1, 16'h2345, 3);
    endtask

    task automatic staCycleTest();
        startProgram(16'h0800);
        emitAbs(OP_STA_ABS, 16'h3200);
        jumpSelf();
        pulseReset();
        waitForSyncs(2, BUDGET_SYNC);
        checkSyncStep(1, 16'h0803, 4);
    endtask

    task automatic stallTest();
        addr_t refAddr [0:3];
        byte_t refData [0:3];
        byte_t loaded [0:3];
        int    i;
        int    r;
        startProgram(16'h0900);
        for (i = 0; i < 4; i++) begin
            r         = $random(seed);
            loaded[i] = r[7:0];
            u_mem.mem[addr_t'(16'h1300 + i)] = loaded[i];
            emitAbs(OP_LDA_ABS, addr_t'(16'h1300 + i));
            emitAbs(OP_STA_ABS, addr_t'(16'h3300 + i));
        end
        jumpSelf();
        pulseReset();
        waitForWrites(4, BUDGET_STALL);
        for (i = 0; i < 4; i++) begin
            refAddr[i] = u_mem.logAddr[i];
            refData[i] = u_mem.logData[i];
            checkValue("unstalled write address", 32'(refAddr[i]), 32'(16'h3300 + i));
        end
        for (i = 0; i < 1024; i++) begin
            r            = $random(seed);
            stallBits[i] = (r[1:0] != 2'b00);
        end
        stallMode = 1'b1;
        pulseReset();
        waitForWrites(4, BUDGET_STALL);
        // Let the jump loop run so that a stray write shows.
        waitForSyncs(syncCount + 2, BUDGET_SYNC);
        stallMode = 1'b0;
        checkValue("stalled write count", 32'(u_mem.writeCount), 32'd4);
        for (i = 0; i < 4; i++) begin
            checkValue("stalled write address", 32'(u_mem.logAddr[i]), 32'(refAddr[i]));
            checkValue("stalled write data", 32'(u_mem.logData[i]), 32'(refData[i]));
            checkValue("stored value", 32'(u_mem.logData[i]), 32'(loaded[i]));
        end
    endtask

    initial begin
        rst       = 1'b1;
        stallMode = 1'b0;
        seed      = 1;
        fillMemory();
        resetVectorTest();
        loadStoreTest();
        arithTest(OP_ADC_IMM);
        arithTest(OP_AND_IMM);
        arithTest(OP_EOR_IMM);
        branchConditionTest();
        branchNearTest();
        branchCrossTest();
        jumpTest();
        staCycleTest();
        stallTest();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* src.f */
rtl/cpuPkg.sv
rtl/sequencer.sv
rtl/addressUnit.sv
rtl/aluUnit.sv
rtl/cpuTop.sv
bench/tbMemory.sv
bench/tbCpu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tbCpu -f src.f -o simCpu \
    && ./obj_dir/simCpu | tee sim.log

grep -q "^TB PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
